// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal -f lsu_pipe.f --top-module lsu_pipe_tb -o lsu_pipe_sim
	@out=$$(./obj_dir/lsu_pipe_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: bench/lsu_pipe_tests.svh
`ifndef LSU_PIPE_TESTS_SVH
`define LSU_PIPE_TESTS_SVH

// ------------------------------
// Encoders and reference model
// ------------------------------
function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [11:0] imm);
  return {imm, 5'd1, f3, rd, 7'b0000011};
endfunction

function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
  return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] eff_addr(input logic [31:0] base, input logic [11:0] imm);
  return base + {{20{imm[11]}}, imm};
endfunction

task automatic model_store(input logic [31:0] addr, input logic [1:0] size,
                           input logic [63:0] data);
  for (int i = 0; i < (1 << size); i++) begin
    ref_mem[(addr + i) & 32'h3ff] = data[i*8 +: 8];
  end
endtask

function automatic logic [63:0] model_load(input logic [31:0] addr, input logic [2:0] f3);
  logic [63:0] val;
  int          nbits;
  val   = '0;
  nbits = 8 << f3[1:0];
  for (int i = 0; i < (1 << f3[1:0]); i++) begin
    val[i*8 +: 8] = ref_mem[(addr + i) & 32'h3ff];
  end
  // Signed narrow loads copy the top bit upward
  if (!f3[2] && nbits < 64 && val[nbits-1]) begin
    val = val | ({64{1'b1}} << nbits);
  end
  return val;
endfunction

// ------------------------------
// Drive and check helpers
// ------------------------------
task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
  assert (got === exp) else begin
    error_count++;
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  end
endtask

task automatic clear_issue();
  i_rs_valid = 1'b0;
  i_rs_inst  = '0;
  i_rs_rs1   = '0;
  i_rs_rs2   = '0;
  i_rs_rd    = '0;
  i_rs_tag   = '0;
  i_rp_valid = 1'b0;
  i_rp_inst  = '0;
  i_rp_rs1   = '0;
  i_rp_rs2   = '0;
  i_rp_rd    = '0;
  i_rp_tag   = '0;
endtask

task automatic drive_rs(input logic [31:0] inst, input logic [63:0] rs1,
                        input logic [63:0] rs2, input logic [4:0] rd);
  i_rs_valid = 1'b1;
  i_rs_inst  = inst;
  i_rs_rs1   = rs1;
  i_rs_rs2   = rs2;
  i_rs_rd    = rd;
  i_rs_tag   = next_tag;
endtask

// Counts cycles from the drive edge until the done pulse
task automatic wait_done(output int lat);
  lat = 0;
  while (!o_done_valid) begin
    @(negedge i_clk);
    lat++;
    check_value("conflict while idle", o_rs_conflict, 0);
    clear_issue();
    assert (lat < 10) else begin
      $display("No done pulse within 10 cycles of an issue");
      $display("Result: FAILED");
      $fatal(1, "no done");
    end
  end
endtask

task automatic do_store(input logic [31:0] base, input logic [11:0] imm,
                        input logic [1:0] size, input logic [63:0] data);
  int lat;
  @(negedge i_clk);
  drive_rs(enc_store({1'b0, size}, imm), base, data, 5'd0);
  wait_done(lat);
  check_value("store done tag", o_done_tag, next_tag);
  check_value("store wb valid", o_wb_valid, 0);
  check_value("store exc valid", o_exc_valid, 0);
  model_store(eff_addr(base, imm), size, data);
  next_tag++;
endtask

task automatic do_load(input logic [31:0] base, input logic [11:0] imm,
                       input logic [2:0] f3, input logic [4:0] rd);
  int lat;
  @(negedge i_clk);
  drive_rs(enc_load(f3, rd, imm), base, 64'd0, rd);
  wait_done(lat);
  check_value("load latency", lat, 4);
  check_value("load wb valid", o_wb_valid, 1);
  check_value("load wb rd", o_wb_rd, rd);
  check_value("load done tag", o_done_tag, next_tag);
  check_value("load data", o_wb_data, model_load(eff_addr(base, imm), f3));
  next_tag++;
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic test_store_load_sizes();
  logic [31:0] addr;
  logic [63:0] data;
  for (int size = 0; size < 4; size++) begin
    repeat (4) begin
      addr = $random(seed);
      addr = addr & (32'h3ff << size);
      data = {$random(seed), $random(seed)};
      do_store(addr, 12'd0, size[1:0], data);
      do_load(addr, 12'd0, {1'b0, size[1:0]}, 5'($random(seed)));
    end
  end
endtask

task automatic test_sign_extension();
  do_store(32'h100, 12'd0, 2'd3, 64'h71e2_53c4_b5a6_9788);
  for (int f3 = 0; f3 < 3; f3++) begin
    do_load(32'h100, 12'd0, f3[2:0], 5'd3);
    do_load(32'h100, 12'd0, {1'b1, f3[1:0]}, 5'd4);
  end
  // Upper half has positive byte and half values
  do_load(32'h100, 12'd5, 3'd0, 5'd5);
  do_load(32'h100, 12'd4, 3'd1, 5'd6);
endtask

task automatic test_negative_offsets();
  do_store(32'h240, 12'hff8, 2'd3, {$random(seed), $random(seed)});
  do_load(32'h240, 12'hff8, 3'd3, 5'd7);
  do_store(32'h240, 12'hfec, 2'd2, {32'd0, $random(seed)});
  do_load(32'h240, 12'hfec, 3'd2, 5'd8);
endtask

task automatic test_misalign();
  int lat;
  do_store(32'h300, 12'd0, 2'd3, 64'h0123_4567_89ab_cdef);
  @(negedge i_clk);
  drive_rs(enc_store(3'd2, 12'd2), 32'h300, 64'hdead_beef_dead_beef, 5'd0);
  wait_done(lat);
  check_value("st misalign exc valid", o_exc_valid, 1);
  check_value("st misalign code", o_exc_code, LSU_EXC_ST_MISALIGN);
  check_value("st misalign wb valid", o_wb_valid, 0);
  next_tag++;
  @(negedge i_clk);
  drive_rs(enc_load(3'd1, 5'd9, 12'd1), 32'h300, 64'd0, 5'd9);
  wait_done(lat);
  check_value("ld misalign exc valid", o_exc_valid, 1);
  check_value("ld misalign code", o_exc_code, LSU_EXC_LD_MISALIGN);
  check_value("ld misalign wb valid", o_wb_valid, 0);
  next_tag++;
  do_load(32'h300, 12'd0, 3'd3, 5'd10);
endtask

task automatic test_replay_priority();
  logic [5:0] rs_tag;
  int         lat;
  do_store(32'h180, 12'd0, 2'd3, 64'h5555_aaaa_1234_8765);
  @(negedge i_clk);
  drive_rs(enc_load(3'd3, 5'd11, 12'd0), 32'h1c0, 64'd0, 5'd11);
  rs_tag = next_tag;
  next_tag++;
  @(negedge i_clk);
  i_rs_valid = 1'b0;
  i_rp_valid = 1'b1;
  i_rp_inst  = enc_load(3'd3, 5'd12, 12'd0);
  i_rp_rs1   = 64'h180;
  i_rp_rd    = 5'd12;
  i_rp_tag   = next_tag;
  #10;
  check_value("replay conflict", o_rs_conflict, 1);
  check_value("replay conflict tag", o_rs_conflict_tag, rs_tag);
  wait_done(lat);
  check_value("replay latency", lat, 3);
  check_value("replay done tag", o_done_tag, next_tag);
  check_value("replay wb valid", o_wb_valid, 1);
  check_value("replay wb rd", o_wb_rd, 12);
  check_value("replay data", o_wb_data, model_load(32'h180, 3'd3));
  next_tag++;
  // Dropped entry must never complete
  repeat (4) begin
    @(negedge i_clk);
    check_value("dropped entry done", o_done_valid, 0);
    check_value("conflict after replay", o_rs_conflict, 0);
  end
endtask

task automatic test_back_to_back();
  logic [63:0] data;
  int          seen;
  data = {$random(seed), $random(seed)};
  @(negedge i_clk);
  drive_rs(enc_store(3'd3, 12'd0), 32'h2a8, data, 5'd0);
  @(negedge i_clk);
  model_store(32'h2a8, 2'd3, data);
  drive_rs(enc_load(3'd3, 5'd13, 12'd0), 32'h2a8, 64'd0, 5'd13);
  i_rs_tag = next_tag + 1'b1;
  seen = 0;
  for (int c = 0; c < 10 && seen < 2; c++) begin
    @(negedge i_clk);
    clear_issue();
    if (o_done_valid) begin
      check_value("b2b done tag", o_done_tag, next_tag + seen);
      check_value("b2b wb valid", o_wb_valid, seen);
      if (seen == 1) begin
        check_value("b2b load data", o_wb_data, data);
      end
      seen++;
    end
  end
  check_value("b2b completions", seen, 2);
  next_tag = next_tag + 2'd2;
endtask

`endif

// File: bench/lsu_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_pipe_tb
  import lsu_pkg::*;
;

  // About 60 operations of under 10 cycles each, with margin
  localparam int CYCLE_LIMIT = 2000;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_rs_valid;
  logic [31:0]           i_rs_inst;
  logic [`LSU_XLEN-1:0]  i_rs_rs1;
  logic [`LSU_XLEN-1:0]  i_rs_rs2;
  logic [`LSU_RD_W-1:0]  i_rs_rd;
  logic [`LSU_TAG_W-1:0] i_rs_tag;
  logic                  i_rp_valid;
  logic [31:0]           i_rp_inst;
  logic [`LSU_XLEN-1:0]  i_rp_rs1;
  logic [`LSU_XLEN-1:0]  i_rp_rs2;
  logic [`LSU_RD_W-1:0]  i_rp_rd;
  logic [`LSU_TAG_W-1:0] i_rp_tag;
  logic                  o_rs_conflict;
  logic [`LSU_TAG_W-1:0] o_rs_conflict_tag;
  logic                  o_wb_valid;
  logic [`LSU_RD_W-1:0]  o_wb_rd;
  logic [`LSU_XLEN-1:0]  o_wb_data;
  logic                  o_done_valid;
  logic [`LSU_TAG_W-1:0] o_done_tag;
  logic                  o_exc_valid;
  lsu_exc_e              o_exc_code;

  // Byte image of the line memory, index wraps like the line index
  logic [7:0] ref_mem [1024];
  int         seed = 52;
  int         cycle_count = 0;
  int         error_count = 0;
  logic [`LSU_TAG_W-1:0] next_tag = '0;

  lsu_pipe u_lsu_pipe (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Simulation did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  `include "lsu_pipe_tests.svh"

  initial begin
    i_reset_n = 1'b0;
    clear_issue();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    check_value("conflict after reset", o_rs_conflict, 0);
    check_value("wb valid after reset", o_wb_valid, 0);
    check_value("done after reset", o_done_valid, 0);
    check_value("exc after reset", o_exc_valid, 0);

    test_store_load_sizes();
    test_sign_extension();
    test_negative_offsets();
    test_misalign();
    test_replay_priority();
    test_back_to_back();

    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_addr_gen
  import lsu_pkg::*;
(
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_rs_valid,
  input  logic [31:0]                       i_rs_inst,
  input  logic [`LSU_XLEN-1:0]              i_rs_rs1,
  input  logic [`LSU_XLEN-1:0]              i_rs_rs2,
  input  logic [`LSU_RD_W-1:0]              i_rs_rd,
  input  logic [`LSU_TAG_W-1:0]             i_rs_tag,

  input  logic                              i_rp_valid,
  input  logic [31:0]                       i_rp_inst,
  input  logic [`LSU_XLEN-1:0]              i_rp_rs1,
  input  logic [`LSU_XLEN-1:0]              i_rp_rs2,
  input  logic [`LSU_RD_W-1:0]              i_rp_rd,
  input  logic [`LSU_TAG_W-1:0]             i_rp_tag,

  output logic                              o_rs_conflict,
  output logic [`LSU_TAG_W-1:0]             o_rs_conflict_tag,

  output logic                              o_rd_en,
  output logic [$clog2(`LSU_RAM_DEPTH)-1:0] o_line_idx,
  output logic                              o_wr_en,
  output logic [`LSU_LINE_BYTES-1:0]        o_wr_mask,
  output logic [`LSU_LINE_W-1:0]            o_wr_line,

  output logic                              o_ex2_valid,
  output lsu_op_e                           o_ex2_op,
  output lsu_size_e                         o_ex2_size,
  output logic                              o_ex2_signed,
  output logic [`LSU_OFS_W-1:0]             o_ex2_ofs,
  output logic [`LSU_RD_W-1:0]              o_ex2_rd,
  output logic [`LSU_TAG_W-1:0]             o_ex2_tag,
  output lsu_exc_e                          o_ex2_exc
);

  logic                    r_rs_valid;
  logic [31:0]             r_rs_inst;
  logic [`LSU_XLEN-1:0]    r_rs_rs1;
  logic [`LSU_XLEN-1:0]    r_rs_rs2;
  logic [`LSU_RD_W-1:0]    r_rs_rd;
  logic [`LSU_TAG_W-1:0]   r_rs_tag;

  logic                    w_ex0_valid;
  logic [31:0]             w_ex0_inst;
  logic [`LSU_XLEN-1:0]    w_ex0_rs1;
  logic [`LSU_XLEN-1:0]    w_ex0_rs2;
  logic [`LSU_RD_W-1:0]    w_ex0_rd;
  logic [`LSU_TAG_W-1:0]   w_ex0_tag;
  lsu_op_e                 w_ex0_op;
  logic [11:0]             w_ex0_imm;

  logic                    r_ex1_valid;
  lsu_op_e                 r_ex1_op;
  lsu_size_e               r_ex1_size;
  logic                    r_ex1_signed;
  logic [11:0]             r_ex1_imm;
  logic [`LSU_XLEN-1:0]    r_ex1_rs1;
  logic [`LSU_XLEN-1:0]    r_ex1_rs2;
  logic [`LSU_RD_W-1:0]    r_ex1_rd;
  logic [`LSU_TAG_W-1:0]   r_ex1_tag;

  logic [`LSU_ADDR_W-1:0]  w_ex1_addr;
  logic [`LSU_OFS_W-1:0]   w_ex1_ofs;
  logic                    w_ex1_misalign;
  logic [7:0]              w_ex1_size_mask;
  lsu_exc_e                w_ex1_exc;

  // ------------------------------
  // EX0 issue select and decode
  // ------------------------------
  // Replay wins, the registered RS entry is dropped
  always_comb begin
    if (i_rp_valid) begin
      w_ex0_inst = i_rp_inst;
      w_ex0_rs1  = i_rp_rs1;
      w_ex0_rs2  = i_rp_rs2;
      w_ex0_rd   = i_rp_rd;
      w_ex0_tag  = i_rp_tag;
    end else begin
      w_ex0_inst = r_rs_inst;
      w_ex0_rs1  = r_rs_rs1;
      w_ex0_rs2  = r_rs_rs2;
      w_ex0_rd   = r_rs_rd;
      w_ex0_tag  = r_rs_tag;
    end
  end

  assign w_ex0_valid       = i_rp_valid | r_rs_valid;
  assign o_rs_conflict     = i_rp_valid & r_rs_valid;
  assign o_rs_conflict_tag = r_rs_tag;

  always_comb begin
    case (w_ex0_inst[6:0])
      LSU_MAJ_LOAD:  w_ex0_op = LSU_OP_LOAD;
      LSU_MAJ_STORE: w_ex0_op = LSU_OP_STORE;
      default:       w_ex0_op = LSU_OP_NONE;
    endcase
  end

  // S-type for stores, I-type otherwise
  assign w_ex0_imm = (w_ex0_op == LSU_OP_STORE) ? {w_ex0_inst[31:25], w_ex0_inst[11:7]}
                                                : w_ex0_inst[31:20];

  // ------------------------------
  // EX1 address and alignment
  // ------------------------------
  assign w_ex1_addr = r_ex1_rs1[`LSU_ADDR_W-1:0]
                    + {{(`LSU_ADDR_W-12){r_ex1_imm[11]}}, r_ex1_imm};
  assign w_ex1_ofs  = w_ex1_addr[`LSU_OFS_W-1:0];

  always_comb begin
    case (r_ex1_size)
      LSU_SIZE_B: begin
        w_ex1_misalign  = 1'b0;
        w_ex1_size_mask = 8'h01;
      end
      LSU_SIZE_H: begin
        w_ex1_misalign  = w_ex1_addr[0];
        w_ex1_size_mask = 8'h03;
      end
      LSU_SIZE_W: begin
        w_ex1_misalign  = |w_ex1_addr[1:0];
        w_ex1_size_mask = 8'h0f;
      end
      default: begin
        w_ex1_misalign  = |w_ex1_addr[2:0];
        w_ex1_size_mask = 8'hff;
      end
    endcase
  end

  always_comb begin
    if (!w_ex1_misalign) begin
      w_ex1_exc = LSU_EXC_NONE;
    end else if (r_ex1_op == LSU_OP_LOAD) begin
      w_ex1_exc = LSU_EXC_LD_MISALIGN;
    end else begin
      w_ex1_exc = LSU_EXC_ST_MISALIGN;
    end
  end

  // Upper address bits above the index alias onto the same lines
  assign o_rd_en    = r_ex1_valid & (r_ex1_op == LSU_OP_LOAD) & ~w_ex1_misalign;
  assign o_line_idx = w_ex1_addr[`LSU_OFS_W +: $clog2(`LSU_RAM_DEPTH)];
  assign o_wr_en    = r_ex1_valid & (r_ex1_op == LSU_OP_STORE) & ~w_ex1_misalign;
  assign o_wr_mask  = {{(`LSU_LINE_BYTES-8){1'b0}}, w_ex1_size_mask} << w_ex1_ofs;
  assign o_wr_line  = {{(`LSU_LINE_W-`LSU_XLEN){1'b0}}, r_ex1_rs2} << {w_ex1_ofs, 3'b000};

  // ------------------------------
  // Pipeline registers
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rs_valid  <= 1'b0;
      r_ex1_valid <= 1'b0;
      o_ex2_valid <= 1'b0;
    end else begin
      r_rs_valid  <= i_rs_valid;
      // Non-memory instructions die here
      r_ex1_valid <= w_ex0_valid & (w_ex0_op != LSU_OP_NONE);
      o_ex2_valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rs_inst    <= i_rs_inst;
    r_rs_rs1     <= i_rs_rs1;
    r_rs_rs2     <= i_rs_rs2;
    r_rs_rd      <= i_rs_rd;
    r_rs_tag     <= i_rs_tag;

    r_ex1_op     <= w_ex0_op;
    r_ex1_size   <= lsu_size_e'(w_ex0_inst[13:12]);
    r_ex1_signed <= ~w_ex0_inst[14];
    r_ex1_imm    <= w_ex0_imm;
    r_ex1_rs1    <= w_ex0_rs1;
    r_ex1_rs2    <= w_ex0_rs2;
    r_ex1_rd     <= w_ex0_rd;
    r_ex1_tag    <= w_ex0_tag;

    o_ex2_op     <= r_ex1_op;
    o_ex2_size   <= r_ex1_size;
    o_ex2_signed <= r_ex1_signed;
    o_ex2_ofs    <= w_ex1_ofs;
    o_ex2_rd     <= r_ex1_rd;
    o_ex2_tag    <= r_ex1_tag;
    o_ex2_exc    <= w_ex1_exc;
  end

endmodule

`default_nettype wire

// File: logic/lsu_line_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_line_ram (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_rd_en,
  input  logic [$clog2(`LSU_RAM_DEPTH)-1:0] i_line_idx,

  input  logic                              i_wr_en,
  input  logic [`LSU_LINE_BYTES-1:0]        i_wr_mask,
  input  logic [`LSU_LINE_W-1:0]            i_wr_line,

  output logic [`LSU_LINE_W-1:0]            o_line
);

  logic [`LSU_LINE_W-1:0] r_mem [`LSU_RAM_DEPTH];
  logic [`LSU_LINE_W-1:0] r_line;

  // ------------------------------
  // Byte-lane write port
  // ------------------------------
  // Read and write share the index, only one op sits in EX1
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `LSU_LINE_BYTES; b++) begin
        if (i_wr_mask[b]) begin
          r_mem[i_line_idx][b*8 +: 8] <= i_wr_line[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Registered read port
  // ------------------------------
  // Holds the last line between loads
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_line <= '0;
    end else if (i_rd_en) begin
      r_line <= r_mem[i_line_idx];
    end
  end

  assign o_line = r_line;

endmodule

`default_nettype wire

// File: logic/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  logic [`LSU_LINE_W-1:0] i_line,

  input  logic                   i_ex2_valid,
  input  lsu_op_e                i_ex2_op,
  input  lsu_size_e              i_ex2_size,
  input  logic                   i_ex2_signed,
  input  logic [`LSU_OFS_W-1:0]  i_ex2_ofs,
  input  logic [`LSU_RD_W-1:0]   i_ex2_rd,
  input  logic [`LSU_TAG_W-1:0]  i_ex2_tag,
  input  lsu_exc_e               i_ex2_exc,

  output logic                   o_wb_valid,
  output logic [`LSU_RD_W-1:0]   o_wb_rd,
  output logic [`LSU_XLEN-1:0]   o_wb_data,

  output logic                   o_done_valid,
  output logic [`LSU_TAG_W-1:0]  o_done_tag,

  output logic                   o_exc_valid,
  output lsu_exc_e               o_exc_code
);

  logic [`LSU_LINE_W-1:0] w_line_shift;
  logic [`LSU_XLEN-1:0]   w_raw;
  logic [`LSU_XLEN-1:0]   w_ext;
  logic                   w_ld_ok;
  logic                   w_has_exc;

  // ------------------------------
  // EX2 byte extraction
  // ------------------------------
  // Addressed bytes moved down to bit 0
  assign w_line_shift = i_line >> {i_ex2_ofs, 3'b000};
  assign w_raw        = w_line_shift[`LSU_XLEN-1:0];

  always_comb begin
    case (i_ex2_size)
      LSU_SIZE_B: begin
        w_ext = {{(`LSU_XLEN-8){i_ex2_signed & w_raw[7]}}, w_raw[7:0]};
      end
      LSU_SIZE_H: begin
        w_ext = {{(`LSU_XLEN-16){i_ex2_signed & w_raw[15]}}, w_raw[15:0]};
      end
      LSU_SIZE_W: begin
        w_ext = {{(`LSU_XLEN-32){i_ex2_signed & w_raw[31]}}, w_raw[31:0]};
      end
      default: begin
        w_ext = w_raw;
      end
    endcase
  end

  assign w_has_exc = (i_ex2_exc != LSU_EXC_NONE);
  assign w_ld_ok   = (i_ex2_op == LSU_OP_LOAD) & ~w_has_exc;

  // ------------------------------
  // EX3 writeback and done
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_wb_valid   <= 1'b0;
      o_done_valid <= 1'b0;
      o_exc_valid  <= 1'b0;
    end else begin
      o_wb_valid   <= i_ex2_valid & w_ld_ok;
      // Stores and faulting ops still complete
      o_done_valid <= i_ex2_valid;
      o_exc_valid  <= i_ex2_valid & w_has_exc;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_rd    <= i_ex2_rd;
    o_wb_data  <= w_ext;
    o_done_tag <= i_ex2_tag;
    o_exc_code <= i_ex2_exc;
  end

endmodule

`default_nettype wire

// File: logic/lsu_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_pipe
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_rs_valid,
  input  logic [31:0]           i_rs_inst,
  input  logic [`LSU_XLEN-1:0]  i_rs_rs1,
  input  logic [`LSU_XLEN-1:0]  i_rs_rs2,
  input  logic [`LSU_RD_W-1:0]  i_rs_rd,
  input  logic [`LSU_TAG_W-1:0] i_rs_tag,

  input  logic                  i_rp_valid,
  input  logic [31:0]           i_rp_inst,
  input  logic [`LSU_XLEN-1:0]  i_rp_rs1,
  input  logic [`LSU_XLEN-1:0]  i_rp_rs2,
  input  logic [`LSU_RD_W-1:0]  i_rp_rd,
  input  logic [`LSU_TAG_W-1:0] i_rp_tag,

  output logic                  o_rs_conflict,
  output logic [`LSU_TAG_W-1:0] o_rs_conflict_tag,

  output logic                  o_wb_valid,
  output logic [`LSU_RD_W-1:0]  o_wb_rd,
  output logic [`LSU_XLEN-1:0]  o_wb_data,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output logic                  o_exc_valid,
  output lsu_exc_e              o_exc_code
);

  // EX1 memory requests
  logic                              a_rd_en;
  logic [$clog2(`LSU_RAM_DEPTH)-1:0] a_line_idx;
  logic                              a_wr_en;
  logic [`LSU_LINE_BYTES-1:0]        a_wr_mask;
  logic [`LSU_LINE_W-1:0]            a_wr_line;

  // EX2 control
  logic                              a_ex2_valid;
  lsu_op_e                           a_ex2_op;
  lsu_size_e                         a_ex2_size;
  logic                              a_ex2_signed;
  logic [`LSU_OFS_W-1:0]             a_ex2_ofs;
  logic [`LSU_RD_W-1:0]              a_ex2_rd;
  logic [`LSU_TAG_W-1:0]             a_ex2_tag;
  lsu_exc_e                          a_ex2_exc;

  logic [`LSU_LINE_W-1:0]            r_line;

  lsu_addr_gen u_addr_gen (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_rs_valid        (i_rs_valid),
    .i_rs_inst         (i_rs_inst),
    .i_rs_rs1          (i_rs_rs1),
    .i_rs_rs2          (i_rs_rs2),
    .i_rs_rd           (i_rs_rd),
    .i_rs_tag          (i_rs_tag),
    .i_rp_valid        (i_rp_valid),
    .i_rp_inst         (i_rp_inst),
    .i_rp_rs1          (i_rp_rs1),
    .i_rp_rs2          (i_rp_rs2),
    .i_rp_rd           (i_rp_rd),
    .i_rp_tag          (i_rp_tag),
    .o_rs_conflict     (o_rs_conflict),
    .o_rs_conflict_tag (o_rs_conflict_tag),
    .o_rd_en           (a_rd_en),
    .o_line_idx        (a_line_idx),
    .o_wr_en           (a_wr_en),
    .o_wr_mask         (a_wr_mask),
    .o_wr_line         (a_wr_line),
    .o_ex2_valid       (a_ex2_valid),
    .o_ex2_op          (a_ex2_op),
    .o_ex2_size        (a_ex2_size),
    .o_ex2_signed      (a_ex2_signed),
    .o_ex2_ofs         (a_ex2_ofs),
    .o_ex2_rd          (a_ex2_rd),
    .o_ex2_tag         (a_ex2_tag),
    .o_ex2_exc         (a_ex2_exc)
  );

  lsu_line_ram u_line_ram (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_en    (a_rd_en),
    .i_line_idx (a_line_idx),
    .i_wr_en    (a_wr_en),
    .i_wr_mask  (a_wr_mask),
    .i_wr_line  (a_wr_line),
    .o_line     (r_line)
  );

  lsu_load_align u_load_align (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_line       (r_line),
    .i_ex2_valid  (a_ex2_valid),
    .i_ex2_op     (a_ex2_op),
    .i_ex2_size   (a_ex2_size),
    .i_ex2_signed (a_ex2_signed),
    .i_ex2_ofs    (a_ex2_ofs),
    .i_ex2_rd     (a_ex2_rd),
    .i_ex2_tag    (a_ex2_tag),
    .i_ex2_exc    (a_ex2_exc),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag),
    .o_exc_valid  (o_exc_valid),
    .o_exc_code   (o_exc_code)
  );

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Major opcodes of the memory instructions
  typedef enum logic [6:0] {
    LSU_MAJ_LOAD  = 7'b0000011,
    LSU_MAJ_STORE = 7'b0100011
  } lsu_major_e;

  typedef enum logic [1:0] {
    LSU_OP_NONE  = 2'd0,
    LSU_OP_LOAD  = 2'd1,
    LSU_OP_STORE = 2'd2
  } lsu_op_e;

  // Low two bits of funct3
  typedef enum logic [1:0] {
    LSU_SIZE_B = 2'd0,
    LSU_SIZE_H = 2'd1,
    LSU_SIZE_W = 2'd2,
    LSU_SIZE_D = 2'd3
  } lsu_size_e;

  // Values as seen on o_exc_code
  typedef enum logic [1:0] {
    LSU_EXC_NONE        = 2'd0,
    LSU_EXC_LD_MISALIGN = 2'd1,
    LSU_EXC_ST_MISALIGN = 2'd2
  } lsu_exc_e;

endpackage

`default_nettype wire

// File: logic/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath widths
`define LSU_XLEN       64
`define LSU_ADDR_W     32

// Line memory geometry
`define LSU_LINE_BYTES 16
`define LSU_LINE_W     128
`define LSU_OFS_W      4
`define LSU_RAM_DEPTH  64

// Identifiers carried with each operation
`define LSU_TAG_W      6
`define LSU_RD_W       5

`endif

// File: lsu_pipe.f
+incdir+logic
+incdir+bench
logic/lsu_pkg.sv
logic/lsu_addr_gen.sv
logic/lsu_line_ram.sv
logic/lsu_load_align.sv
logic/lsu_pipe.sv
bench/lsu_pipe_tb.sv
